/* source/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    parameter int WORD_WIDTH = 32;
    parameter int REG_ADDR_WIDTH = 5;
    parameter int OPCODE_WIDTH = 6;
    parameter int FUNCT_WIDTH = 6;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [FUNCT_WIDTH-1:0] {
        FUNCT_JR  = 6'h08,
        FUNCT_ADD = 6'h20,
        FUNCT_SUB = 6'h22,
        FUNCT_AND = 6'h24,
        FUNCT_SLT = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        PASS_A,
        ADD,
        SUB,
        AND,
        SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        REG_B,
        FOUR,
        SIGN_IMM,
        BRANCH_OFFSET    // Immediate times four
    } alu_src_b_t;

    typedef enum logic [1:0] {
        PC_ALU_RESULT,
        PC_ALUOUT,
        PC_JUMP
    } pc_source_t;

    typedef enum logic [1:0] {
        RT,
        RD,
        LINK    // r31
    } reg_dst_t;

    typedef enum logic [1:0] {
        WB_ALUOUT,
        WB_MDR,
        WB_UPPER_IMM,
        WB_PC
    } mem_to_reg_t;

    typedef struct packed {
        opcode_t opcode;
        funct_t  funct;
    } decode_t;

    typedef struct packed {
        logic        pc_write;
        logic        branch_write;
        logic        branch_on_equal;
        logic        iord;          // Address from ALUOut
        logic        mem_write;
        logic        ir_load;
        logic        mdr_load;
        logic        ab_load;
        logic        aluout_load;
        logic        alu_src_a;     // Register A instead of PC
        alu_src_b_t  alu_src_b;
        alu_op_t     alu_op;
        pc_source_t  pc_source;
        reg_dst_t    reg_dst;
        mem_to_reg_t mem_to_reg;
        logic        reg_write;
    } ctrl_word_t;

endpackage

`default_nettype wire

/* source/mips_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_alu import mips_pkg::*; (
    input  logic [WORD_WIDTH-1:0] a,
    input  logic [WORD_WIDTH-1:0] b,
    input  alu_op_t               op,
    output logic [WORD_WIDTH-1:0] result,
    output logic                  zero
);

    logic less;

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            PASS_A: result = a;
            ADD: result = a + b;    // Wraps, no overflow trap
            SUB: result = a - b;
            AND: result = a & b;
            SLT: result = {{(WORD_WIDTH-1){1'b0}}, less};
            default: result = a;
        endcase
    end

    // Used by beq and bne after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* source/mips_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_regfile import mips_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [REG_ADDR_WIDTH-1:0] raddr_a,
    input  logic [REG_ADDR_WIDTH-1:0] raddr_b,
    output logic [WORD_WIDTH-1:0]     rdata_a,
    output logic [WORD_WIDTH-1:0]     rdata_b,
    input  logic [REG_ADDR_WIDTH-1:0] waddr,
    input  logic [WORD_WIDTH-1:0]     wdata,
    input  logic                      write
);

    localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

    logic [WORD_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Entry 0 is never written so it reads as zero
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

/* source/mips_control.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_control import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  decode_t    decode,
    output ctrl_word_t ctrl
);

    typedef enum logic [4:0] {
        FETCH,
        IR_LOAD,
        DECODE,
        EXEC_ADD,
        EXEC_SUB,
        EXEC_AND,
        EXEC_SLT,
        EXEC_ADDI,
        EXEC_SLTI,
        WB_RD,
        WB_RT,
        WB_LUI,
        ADDRESS,
        MEM_READ,
        MEM_WAIT,
        WB_LOAD,
        STORE,
        BRANCH_EQ,
        BRANCH_NE,
        JUMP,
        JR_READ,
        JR_JUMP,
        JAL_LINK
    } state_t;

    state_t state;
    state_t next_state;

    // Outputs belonging to each state
    function automatic ctrl_word_t ctrl_for(state_t s);
        ctrl_word_t c;
        c = '0;
        c.alu_src_b = REG_B;
        c.alu_op = ADD;
        c.pc_source = PC_ALU_RESULT;
        c.reg_dst = RT;
        c.mem_to_reg = WB_ALUOUT;
        case (s)
            IR_LOAD: begin
                c.ir_load = 1'b1;
                c.alu_src_b = FOUR;
                c.pc_write = 1'b1;
            end
            DECODE: begin
                c.ab_load = 1'b1;
                c.alu_src_b = BRANCH_OFFSET;    // Branch target into ALUOut
                c.aluout_load = 1'b1;
            end
            EXEC_ADD, EXEC_SUB, EXEC_AND, EXEC_SLT: begin
                c.alu_src_a = 1'b1;
                c.aluout_load = 1'b1;
                if (s == EXEC_SUB) begin
                    c.alu_op = SUB;
                end else if (s == EXEC_AND) begin
                    c.alu_op = AND;
                end else if (s == EXEC_SLT) begin
                    c.alu_op = SLT;
                end
            end
            EXEC_ADDI, EXEC_SLTI, ADDRESS: begin
                c.alu_src_a = 1'b1;
                c.alu_src_b = SIGN_IMM;
                c.aluout_load = 1'b1;
                if (s == EXEC_SLTI) begin
                    c.alu_op = SLT;
                end
            end
            WB_RD: begin
                c.reg_dst = RD;
                c.reg_write = 1'b1;
            end
            WB_RT: c.reg_write = 1'b1;
            WB_LUI: begin
                c.mem_to_reg = WB_UPPER_IMM;
                c.reg_write = 1'b1;
            end
            MEM_READ: c.iord = 1'b1;
            MEM_WAIT: begin
                c.iord = 1'b1;
                c.mdr_load = 1'b1;
            end
            WB_LOAD: begin
                c.mem_to_reg = WB_MDR;
                c.reg_write = 1'b1;
            end
            STORE: begin
                c.iord = 1'b1;
                c.mem_write = 1'b1;
            end
            BRANCH_EQ, BRANCH_NE: begin
                c.alu_src_a = 1'b1;
                c.alu_op = SUB;
                c.branch_write = 1'b1;
                c.branch_on_equal = (s == BRANCH_EQ);
                c.pc_source = PC_ALUOUT;
            end
            JUMP: begin
                c.pc_source = PC_JUMP;
                c.pc_write = 1'b1;
            end
            JR_READ: begin
                c.alu_src_a = 1'b1;
                c.alu_op = PASS_A;
                c.aluout_load = 1'b1;
            end
            JR_JUMP: begin
                c.pc_source = PC_ALUOUT;
                c.pc_write = 1'b1;
            end
            JAL_LINK: begin
                c.reg_dst = LINK;
                c.mem_to_reg = WB_PC;    // PC already past the jal
                c.reg_write = 1'b1;
            end
            default: c.iord = 1'b0;    // FETCH reads at PC
        endcase
        return c;
    endfunction

    always_comb begin
        next_state = FETCH;
        case (state)
            FETCH: next_state = IR_LOAD;
            IR_LOAD: next_state = DECODE;
            DECODE: begin
                case (decode.opcode)
                    OP_RTYPE: begin
                        case (decode.funct)
                            FUNCT_ADD: next_state = EXEC_ADD;
                            FUNCT_SUB: next_state = EXEC_SUB;
                            FUNCT_AND: next_state = EXEC_AND;
                            FUNCT_SLT: next_state = EXEC_SLT;
                            FUNCT_JR: next_state = JR_READ;
                            default: next_state = FETCH;
                        endcase
                    end
                    OP_ADDI: next_state = EXEC_ADDI;
                    OP_SLTI: next_state = EXEC_SLTI;
                    OP_LUI: next_state = WB_LUI;
                    OP_LW, OP_SW: next_state = ADDRESS;
                    OP_BEQ: next_state = BRANCH_EQ;
                    OP_BNE: next_state = BRANCH_NE;
                    OP_J: next_state = JUMP;
                    OP_JAL: next_state = JAL_LINK;
                    default: next_state = FETCH;    // Unknown opcode
                endcase
            end
            EXEC_ADD, EXEC_SUB, EXEC_AND, EXEC_SLT: next_state = WB_RD;
            EXEC_ADDI, EXEC_SLTI: next_state = WB_RT;
            ADDRESS: next_state = (decode.opcode == OP_SW) ? STORE : MEM_READ;
            MEM_READ: next_state = MEM_WAIT;
            MEM_WAIT: next_state = WB_LOAD;
            JR_READ: next_state = JR_JUMP;
            JAL_LINK: next_state = JUMP;
            default: next_state = FETCH;
        endcase
    end

    // Control word registered together with the state
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            ctrl <= ctrl_for(FETCH);
        end else begin
            state <= next_state;
            ctrl <= ctrl_for(next_state);
        end
    end

endmodule

`default_nettype wire

/* source/mips_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_datapath import mips_pkg::*; #(
    parameter logic [WORD_WIDTH-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  ctrl_word_t                ctrl,
    output decode_t                   decode,
    output logic [WORD_WIDTH-1:0]     mem_addr,
    output logic [WORD_WIDTH-1:0]     mem_wdata,
    input  logic [WORD_WIDTH-1:0]     mem_rdata,
    output logic [WORD_WIDTH-1:0]     alu_a,
    output logic [WORD_WIDTH-1:0]     alu_b,
    output alu_op_t                   alu_op,
    input  logic [WORD_WIDTH-1:0]     alu_result,
    input  logic                      alu_zero,
    output logic [REG_ADDR_WIDTH-1:0] rf_raddr_a,
    output logic [REG_ADDR_WIDTH-1:0] rf_raddr_b,
    input  logic [WORD_WIDTH-1:0]     rf_rdata_a,
    input  logic [WORD_WIDTH-1:0]     rf_rdata_b,
    output logic [REG_ADDR_WIDTH-1:0] rf_waddr,
    output logic [WORD_WIDTH-1:0]     rf_wdata,
    output logic                      rf_write
);

    logic [WORD_WIDTH-1:0] pc;
    logic [WORD_WIDTH-1:0] ir;
    logic [WORD_WIDTH-1:0] mdr;
    logic [WORD_WIDTH-1:0] a_reg;
    logic [WORD_WIDTH-1:0] b_reg;
    logic [WORD_WIDTH-1:0] alu_out;
    logic [WORD_WIDTH-1:0] sign_imm;
    logic [WORD_WIDTH-1:0] jump_target;
    logic [WORD_WIDTH-1:0] pc_next;
    logic                  pc_en;

    assign decode.opcode = opcode_t'(ir[WORD_WIDTH-1 -: OPCODE_WIDTH]);
    assign decode.funct = funct_t'(ir[FUNCT_WIDTH-1:0]);

    assign sign_imm = {{(WORD_WIDTH-16){ir[15]}}, ir[15:0]};
    assign jump_target = {pc[WORD_WIDTH-1 -: 4], ir[25:0], 2'b00};

    // ALU operands
    assign alu_a = ctrl.alu_src_a ? a_reg : pc;
    assign alu_op = ctrl.alu_op;

    always_comb begin
        case (ctrl.alu_src_b)
            REG_B: alu_b = b_reg;
            FOUR: alu_b = WORD_WIDTH'(4);
            SIGN_IMM: alu_b = sign_imm;
            default: alu_b = {sign_imm[WORD_WIDTH-3:0], 2'b00};
        endcase
    end

    assign mem_addr = ctrl.iord ? alu_out : pc;
    assign mem_wdata = b_reg;

    // Register file side
    assign rf_raddr_a = ir[25:21];
    assign rf_raddr_b = ir[20:16];
    assign rf_write = ctrl.reg_write;

    always_comb begin
        case (ctrl.reg_dst)
            RD: rf_waddr = ir[15:11];
            LINK: rf_waddr = '1;
            default: rf_waddr = ir[20:16];
        endcase
    end

    always_comb begin
        case (ctrl.mem_to_reg)
            WB_MDR: rf_wdata = mdr;
            WB_UPPER_IMM: rf_wdata = {ir[15:0], 16'b0};
            WB_PC: rf_wdata = pc;
            default: rf_wdata = alu_out;
        endcase
    end

    // Next PC and the branch decision
    always_comb begin
        case (ctrl.pc_source)
            PC_ALUOUT: pc_next = alu_out;
            PC_JUMP: pc_next = jump_target;
            default: pc_next = alu_result;
        endcase
    end

    assign pc_en = ctrl.pc_write | (ctrl.branch_write & (alu_zero == ctrl.branch_on_equal));

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_load) begin
            ir <= mem_rdata;
        end
        if (ctrl.mdr_load) begin
            mdr <= mem_rdata;
        end
        if (ctrl.ab_load) begin
            a_reg <= rf_rdata_a;
            b_reg <= rf_rdata_b;
        end
        if (ctrl.aluout_load) begin
            alu_out <= alu_result;
        end
    end

endmodule

`default_nettype wire

/* source/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; #(
    parameter logic [WORD_WIDTH-1:0] RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    output logic [WORD_WIDTH-1:0] mem_addr,
    output logic [WORD_WIDTH-1:0] mem_wdata,
    output logic                  mem_write,
    input  logic [WORD_WIDTH-1:0] mem_rdata
);

    ctrl_word_t                ctrl;
    decode_t                   decode;
    logic [WORD_WIDTH-1:0]     alu_a;
    logic [WORD_WIDTH-1:0]     alu_b;
    alu_op_t                   alu_op;
    logic [WORD_WIDTH-1:0]     alu_result;
    logic                      alu_zero;
    logic [REG_ADDR_WIDTH-1:0] rf_raddr_a;
    logic [REG_ADDR_WIDTH-1:0] rf_raddr_b;
    logic [WORD_WIDTH-1:0]     rf_rdata_a;
    logic [WORD_WIDTH-1:0]     rf_rdata_b;
    logic [REG_ADDR_WIDTH-1:0] rf_waddr;
    logic [WORD_WIDTH-1:0]     rf_wdata;
    logic                      rf_write;

    assign mem_write = ctrl.mem_write;

    mips_control control0 (
        .clk    (clk),
        .reset  (reset),
        .decode (decode),
        .ctrl   (ctrl)
    );

    mips_datapath #(
        .RESET_PC (RESET_PC)
    ) datapath0 (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .decode     (decode),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .alu_zero   (alu_zero),
        .rf_raddr_a (rf_raddr_a),
        .rf_raddr_b (rf_raddr_b),
        .rf_rdata_a (rf_rdata_a),
        .rf_rdata_b (rf_rdata_b),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .rf_write   (rf_write)
    );

    mips_alu alu0 (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    mips_regfile regfile0 (
        .clk     (clk),
        .reset   (reset),
        .raddr_a (rf_raddr_a),
        .raddr_b (rf_raddr_b),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .write   (rf_write)
    );

endmodule

`default_nettype wire

/* bench/core_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module core_assertions import mips_pkg::*; (
    input logic                  clk,
    input logic                  reset,
    input logic [WORD_WIDTH-1:0] mem_addr,
    input logic                  mem_write
);

    int failure_count = 0;

    store_one_cycle: assert property (@(negedge clk) disable iff (reset)
        mem_write |=> !mem_write)
        else begin
            failure_count++;
            $error("mem_write stayed high for two consecutive cycles");
        end

    store_aligned: assert property (@(negedge clk) disable iff (reset)
        mem_write |-> mem_addr[1:0] == 2'b00)
        else begin
            failure_count++;
            $error("store to address %h is not word aligned", mem_addr);
        end

    // Sync reset, so the first reset cycle may still finish a store
    no_store_in_reset: assert property (@(negedge clk)
        reset && $past(reset) |-> !mem_write)
        else begin
            failure_count++;
            $error("mem_write high while reset is held");
        end

endmodule

bind mips_core core_assertions assert0 (
    .clk       (clk),
    .reset     (reset),
    .mem_addr  (mem_addr),
    .mem_write (mem_write)
);

`default_nettype wire

/* bench/core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module core_checker import mips_pkg::*; #(
    parameter logic [WORD_WIDTH-1:0] RESET_PC = '0,
    parameter int MEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [WORD_WIDTH-1:0] mem_addr,
    input  logic [WORD_WIDTH-1:0] mem_wdata,
    input  logic                  mem_write,
    output int                    pending,
    output int                    error_count
);

    localparam int MAX_STEPS = 10000;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0] data;
    } store_t;

    store_t                expected [$];
    logic [WORD_WIDTH-1:0] ref_mem [MEM_WORDS];

    initial begin
        pending = 0;
        error_count = 0;
    end

    function automatic int word_index(logic [WORD_WIDTH-1:0] addr);
        return int'((addr >> 2) % MEM_WORDS);
    endfunction

    function automatic void load_word(int index, logic [WORD_WIDTH-1:0] value);
        ref_mem[index] = value;
    endfunction

    // Instruction-set model, runs until the jump to itself
    function automatic void run_reference();
        logic [WORD_WIDTH-1:0] regs [32];
        logic [WORD_WIDTH-1:0] pc;
        logic [WORD_WIDTH-1:0] instr;
        logic [WORD_WIDTH-1:0] imm;
        logic [WORD_WIDTH-1:0] rs_val;
        logic [WORD_WIDTH-1:0] rt_val;
        logic [WORD_WIDTH-1:0] target;
        logic [4:0]            rt;
        logic [4:0]            rd;
        store_t                entry;
        bit                    halted;
        int                    steps;
        expected.delete();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc = RESET_PC;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < MAX_STEPS) begin
            instr = ref_mem[word_index(pc)];
            rs_val = regs[instr[25:21]];
            rt_val = regs[instr[20:16]];
            rt = instr[20:16];
            rd = instr[15:11];
            imm = {{16{instr[15]}}, instr[15:0]};
            pc = pc + 4;
            target = {pc[31:28], instr[25:0], 2'b00};
            case (instr[31:26])
                OP_RTYPE: begin
                    case (instr[5:0])
                        FUNCT_ADD: regs[rd] = rs_val + rt_val;
                        FUNCT_SUB: regs[rd] = rs_val - rt_val;
                        FUNCT_AND: regs[rd] = rs_val & rt_val;
                        FUNCT_SLT: regs[rd] = {31'b0, $signed(rs_val) < $signed(rt_val)};
                        FUNCT_JR: pc = rs_val;
                        default: begin
                        end
                    endcase
                end
                OP_ADDI: regs[rt] = rs_val + imm;
                OP_SLTI: regs[rt] = {31'b0, $signed(rs_val) < $signed(imm)};
                OP_LUI: regs[rt] = {instr[15:0], 16'b0};
                OP_LW: regs[rt] = ref_mem[word_index(rs_val + imm)];
                OP_SW: begin
                    entry.addr = rs_val + imm;
                    entry.data = rt_val;
                    expected.push_back(entry);
                    ref_mem[word_index(entry.addr)] = rt_val;
                end
                OP_BEQ: if (rs_val == rt_val) pc = pc + (imm << 2);
                OP_BNE: if (rs_val != rt_val) pc = pc + (imm << 2);
                OP_J: begin
                    halted = (target == pc - 4);
                    pc = target;
                end
                OP_JAL: begin
                    regs[31] = pc;    // Link is the jal address plus four
                    pc = target;
                end
                default: begin    // Unknown opcode is a no-op
                end
            endcase
            regs[0] = '0;
            steps++;
        end
        if (!halted) begin
            error_count++;
            $display("Reference model never reached the closing jump to itself");
        end
        pending = expected.size();
    endfunction

    // Store stream against the model, in order
    always @(negedge clk) begin
        store_t head;
        if (!reset && mem_write === 1'b1) begin
            if (expected.size() == 0) begin
                error_count++;
                $display("Unexpected store at time %0t to %h with data %h, none was expected",
                         $time, mem_addr, mem_wdata);
            end else begin
                head = expected.pop_front();
                pending = expected.size();
                if (mem_addr !== head.addr) begin
                    error_count++;
                    $display("Mismatch at time %0t: mem_addr is %h, expected %h",
                             $time, mem_addr, head.addr);
                end
                if (mem_wdata !== head.data) begin
                    error_count++;
                    $display("Mismatch at time %0t: mem_wdata is %h, expected %h",
                             $time, mem_wdata, head.data);
                end
            end
        end else if (!reset && mem_write !== 1'b0) begin
            error_count++;
            $display("mem_write is unknown at time %0t", $time);
        end
    end

endmodule

`default_nettype wire

/* bench/tb_mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core import mips_pkg::*; ();

    localparam logic [WORD_WIDTH-1:0] RESET_PC = 32'h0000_0100;
    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT_CYCLES = 2000;

    logic                  clk;
    logic                  reset;
    logic [WORD_WIDTH-1:0] mem_addr;
    logic [WORD_WIDTH-1:0] mem_wdata;
    logic [WORD_WIDTH-1:0] mem_rdata;
    logic                  mem_write;
    logic [WORD_WIDTH-1:0] mem [MEM_WORDS];
    logic [7:0]            read_index;
    int                    pending;
    int                    error_count;
    integer                seed;
    int                    load_ptr;
    int                    tests_run;
    int                    tests_failed;

    mips_core #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_write (mem_write),
        .mem_rdata (mem_rdata)
    );

    core_checker #(
        .RESET_PC  (RESET_PC),
        .MEM_WORDS (MEM_WORDS)
    ) chk0 (
        .clk         (clk),
        .reset       (reset),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_write   (mem_write),
        .pending     (pending),
        .error_count (error_count)
    );

    always #20 clk = ~clk;

    // Memory model, read data one cycle after the address
    always @(negedge clk) begin
        read_index = mem_addr[9:2];
        if (mem_write === 1'b1) begin
            mem[mem_addr[9:2]] = mem_wdata;
        end
    end

    always @(posedge clk) begin
        #1 mem_rdata = mem[read_index];
    end

    function automatic logic [31:0] rtype_word(funct_t fn, int rs, int rt, int rd);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
    endfunction

    function automatic logic [31:0] itype_word(opcode_t op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] jump_word(opcode_t op, int index);
        return {op, 26'(index)};
    endfunction

    task automatic poke(input int index, input logic [31:0] value);
        mem[index] = value;
        chk0.load_word(index, value);
    endtask

    task automatic emit(input logic [31:0] word);
        poke(load_ptr, word);
        load_ptr++;
    endtask

    task automatic put_constant(input int rt, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h8000;    // addi sign-extends the low half
        emit(itype_word(OP_LUI, 0, rt, upper[31:16]));
        emit(itype_word(OP_ADDI, rt, rt, value[15:0]));
    endtask

    task automatic save(input int rt, input int offset);
        emit(itype_word(OP_SW, 0, rt, 16'(offset)));
    endtask

    task automatic build_program(input int id);
        int loop_top;
        for (int i = 0; i < MEM_WORDS; i++) begin
            poke(i, 32'h5a5a_0000 + i);
        end
        load_ptr = RESET_PC / 4;
        case (id)
            1: begin
                for (int k = 0; k < 3; k++) begin
                    put_constant(1, (k == 0) ? 32'h7fff_ffff : $random(seed));
                    put_constant(2, (k == 0) ? 32'h0000_0001 : $random(seed));
                    emit(rtype_word(FUNCT_ADD, 1, 2, 3));    // Wraps on the first pass
                    emit(rtype_word(FUNCT_SUB, 2, 1, 4));
                    emit(rtype_word(FUNCT_AND, 1, 2, 5));
                    emit(rtype_word(FUNCT_SLT, 1, 2, 6));
                    for (int r = 3; r <= 6; r++) begin
                        save(r, 16 * k + 4 * (r - 3));
                    end
                end
            end
            2: begin
                for (int k = 0; k < 3; k++) begin
                    emit(itype_word(OP_ADDI, 0, 1, 16'($random(seed))));
                    emit(itype_word(OP_SLTI, 1, 2, 16'($random(seed))));
                    emit(itype_word(OP_LUI, 0, 3, 16'($random(seed))));
                    emit(itype_word(OP_ADDI, 0, 0, 16'($random(seed))));
                    save(1, 16 * k);
                    save(2, 16 * k + 4);
                    save(3, 16 * k + 8);
                    save(0, 16 * k + 12);
                end
            end
            3: begin
                for (int i = 0; i < 8; i++) begin
                    poke(32 + i, $random(seed));
                end
                emit(itype_word(OP_ADDI, 0, 10, 16'h0080));    // Source words
                emit(itype_word(OP_ADDI, 0, 11, 16'h00c0));
                for (int i = 0; i < 8; i++) begin
                    emit(itype_word(OP_LW, 10, 1, 16'(4 * i)));
                    emit(itype_word(OP_ADDI, 1, 1, 16'($random(seed))));
                    emit(itype_word(OP_SW, 11, 1, 16'h0000));
                    emit(itype_word(OP_ADDI, 11, 11, 16'd4));
                end
            end
            4, 6: begin
                emit(itype_word(OP_ADDI, 0, 2, 16'd5));    // Loop count
                emit(itype_word(OP_ADDI, 0, 3, 16'h0040));
                loop_top = load_ptr;
                emit(itype_word(OP_SW, 3, 1, 16'h0000));
                emit(itype_word(OP_ADDI, 3, 3, 16'd4));
                emit(itype_word(OP_ADDI, 1, 1, 16'd1));
                emit(itype_word(OP_BNE, 1, 2, 16'(loop_top - load_ptr - 1)));
                emit(itype_word(OP_BEQ, 1, 2, 16'd1));    // Taken, skips a store
                save(3, 16'h0070);
                emit(itype_word(OP_BEQ, 1, 0, 16'd1));
                save(1, 16'h0074);
            end
            default: begin
                emit(jump_word(OP_J, load_ptr + 2));
                save(0, 16'h0030);
                emit(jump_word(OP_JAL, load_ptr + 3));
                save(31, 16'h0020);
                emit(jump_word(OP_J, load_ptr));
                emit(itype_word(OP_ADDI, 0, 5, 16'($random(seed))));    // Called routine
                save(5, 16'h0024);
                emit(rtype_word(FUNCT_JR, 31, 0, 0));
            end
        endcase
        emit(jump_word(OP_J, load_ptr));
    endtask

    task automatic start_program(input int id);
        @(posedge clk);
        #1 reset = 1'b1;
        build_program(id);
        chk0.run_reference();
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    task automatic wait_for_pending(input int target, output bit timed_out);
        int cycles;
        cycles = 0;
        while (pending > target && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        timed_out = (pending > target);
    endtask

    task automatic run_test(input int id, input string name, input int restart_after);
        int  errors_before;
        bit  timed_out;
        bit  late;
        bit  passed;
        errors_before = error_count + dut0.assert0.failure_count;
        timed_out = 1'b0;
        start_program(id);
        if (restart_after > 0) begin
            wait_for_pending(pending - restart_after, timed_out);
            start_program(id);    // Mid-program reset
        end
        wait_for_pending(0, late);
        timed_out = timed_out | late;
        if (timed_out) begin
            $display("Test %0d %s: timed out with %0d stores still expected", id, name, pending);
        end
        repeat (50) @(posedge clk);
        passed = !timed_out && (error_count + dut0.assert0.failure_count == errors_before);
        tests_run++;
        if (!passed) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", id, name, passed ? "ok" : "failed");
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        mem_rdata = '0;
        seed = 99248;
        tests_run = 0;
        tests_failed = 0;
        run_test(1, "r-type arithmetic", 0);
        run_test(2, "immediates", 0);
        run_test(3, "loads and stores", 0);
        run_test(4, "branches", 0);
        run_test(5, "jumps and call", 0);
        run_test(6, "reset restart", 3);
        $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
source/mips_pkg.sv
source/mips_alu.sv
source/mips_regfile.sv
source/mips_control.sv
source/mips_datapath.sv
source/mips_core.sv
bench/core_assertions.sv
bench/core_checker.sv
bench/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - files:
      - source/mips_pkg.sv
      - source/mips_alu.sv
      - source/mips_regfile.sv
      - source/mips_control.sv
      - source/mips_datapath.sv
      - source/mips_core.sv
  - target: test
    files:
      - bench/core_assertions.sv
      - bench/core_checker.sv
      - bench/tb_mips_core.sv
